// File: csr_bridge_defs.svh
// ==============================
// Width, register count and register map of the CSR bridge
// Include wherever a width or a register base address is needed
// ==============================
`ifndef CSR_BRIDGE_DEFS_SVH
`define CSR_BRIDGE_DEFS_SVH

// Bus data width and register width are the same
`define CSR_DATA_W 64
`define CSR_ADDR_W 20
`define CSR_NUM_REGS 5
`define CSR_SIZE_W 2

// Base address of each register, 8-byte aligned
`define CSR_ADDR_SCRATCH 20'h00000
`define CSR_ADDR_CTRL 20'h00008
`define CSR_ADDR_COUNT 20'h00010
`define CSR_ADDR_COMPARE 20'h00018
`define CSR_ADDR_STATUS 20'h00020

// Bit positions in the read and write strobe vectors
`define CSR_IDX_SCRATCH 0
`define CSR_IDX_CTRL 1
`define CSR_IDX_COUNT 2
`define CSR_IDX_COMPARE 3
`define CSR_IDX_STATUS 4

`endif

// File: csr_bridge_pkg.sv
// ==============================
// Message types and the command/response header of the bridge
// Refer to members by scoped name from any block that needs them
// ==============================
`include "csr_bridge_defs.svh"

package csr_bridge_pkg;

  // Encoding follows the memory stream, writes are the odd codes
  typedef enum logic [1:0]
  {
    MSG_RD    = 2'd0,
    MSG_WR    = 2'd1,
    MSG_UC_RD = 2'd2,
    MSG_UC_WR = 2'd3
  } msg_e;

  // Access size is log2 of the byte count
  typedef enum logic [`CSR_SIZE_W-1:0]
  {
    SIZE_1 = 2'd0,
    SIZE_2 = 2'd1,
    SIZE_4 = 2'd2,
    SIZE_8 = 2'd3
  } size_e;

  // One header per beat, echoed unchanged on the response
  typedef struct packed
  {
    msg_e                   msg;
    logic [`CSR_ADDR_W-1:0] addr;
    size_e                  size;
  } mem_header_s;

endpackage

// File: reg_bus_if.sv
// ==============================
// Strobe-based register bus from the bridge to the register file
// Bridge drives strobes and write data, the register file returns read data
// ==============================
`timescale 1ns/1ps
`include "csr_bridge_defs.svh"

interface reg_bus_if;

  // One bit per register, at most one bit high in any cycle
  logic [`CSR_NUM_REGS-1:0] r_v;
  logic [`CSR_NUM_REGS-1:0] w_v;
  logic [`CSR_ADDR_W-1:0]   addr;
  csr_bridge_pkg::size_e    size;
  logic [`CSR_DATA_W-1:0]   wdata;
  // Latched read value of each register, held until its next read strobe
  logic [`CSR_NUM_REGS-1:0][`CSR_DATA_W-1:0] rdata;

  modport bridge
  (
    output r_v, w_v, addr, size, wdata,
    input  rdata
  );

  modport regfile
  (
    input  r_v, w_v, addr, size, wdata,
    output rdata
  );

endinterface

// File: fwd_buffer.sv
// ==============================
// Single-entry command buffer in front of the register decoder
// Accepts a beat on valid and ready, holds it until yumi pops it
// ==============================
`timescale 1ns/1ps
`include "csr_bridge_defs.svh"

module fwd_buffer
(
  input  logic                        clk_i,
  input  logic                        rst_n_i,
  input  csr_bridge_pkg::mem_header_s hdr_i,
  input  logic [`CSR_DATA_W-1:0]      data_i,
  input  logic                        v_i,
  output logic                        ready_o,
  output csr_bridge_pkg::mem_header_s hdr_o,
  output logic [`CSR_DATA_W-1:0]      data_o,
  output logic                        v_o,
  input  logic                        yumi_i
);

  logic                        full_r;
  csr_bridge_pkg::mem_header_s hdr_r;
  logic [`CSR_DATA_W-1:0]      data_r;

  // Only an empty buffer takes a new beat, so one command at most is in flight
  assign ready_o = ~full_r;

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
      full_r <= 1'b0;
    else if (v_i && ready_o)
      full_r <= 1'b1;
    else if (yumi_i)
      full_r <= 1'b0;
  end

  // Payload is only looked at while the full flag is set
  always_ff @(posedge clk_i)
  begin
    if (v_i && ready_o)
    begin
      hdr_r  <= hdr_i;
      data_r <= data_i;
    end
  end

  assign hdr_o  = hdr_r;
  assign data_o = data_r;
  assign v_o    = full_r;

endmodule

// File: reg_bridge.sv
// ==============================
// Turns buffered stream commands into one-cycle register strobes
// Every command gets exactly one response, even at an unmapped address
// ==============================
`timescale 1ns/1ps
`include "csr_bridge_defs.svh"

module reg_bridge
(
  input  logic                        clk_i,
  input  logic                        rst_n_i,
  input  csr_bridge_pkg::mem_header_s fwd_hdr_i,
  input  logic [`CSR_DATA_W-1:0]      fwd_data_i,
  input  logic                        fwd_v_i,
  output logic                        fwd_ready_and_o,
  output csr_bridge_pkg::mem_header_s rev_hdr_o,
  output logic [`CSR_DATA_W-1:0]      rev_data_o,
  output logic                        rev_v_o,
  input  logic                        rev_ready_and_i,
  reg_bus_if.bridge                   reg_bus
);

  csr_bridge_pkg::mem_header_s buf_hdr;
  logic [`CSR_DATA_W-1:0]      buf_data;
  logic                        buf_v;
  logic                        buf_yumi;
  logic                        v_r;
  logic                        v_n;
  logic                        wr_not_rd;
  logic [`CSR_NUM_REGS-1:0]    addr_hit;
  logic [`CSR_NUM_REGS-1:0]    r_v_r;
  logic [`CSR_DATA_W-1:0]      rdata_sel;

  // Copies the low 2^size bytes of a word across the whole bus
  function automatic logic [`CSR_DATA_W-1:0] replicate
  (
    input logic [`CSR_DATA_W-1:0] word,
    input csr_bridge_pkg::size_e  size
  );
    case (size)
      csr_bridge_pkg::SIZE_1: replicate = {8{word[7:0]}};
      csr_bridge_pkg::SIZE_2: replicate = {4{word[15:0]}};
      csr_bridge_pkg::SIZE_4: replicate = {2{word[31:0]}};
      default:                replicate = word;
    endcase
  endfunction

  fwd_buffer fwd_buffer_i
  (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .hdr_i   (fwd_hdr_i),
    .data_i  (fwd_data_i),
    .v_i     (fwd_v_i),
    .ready_o (fwd_ready_and_o),
    .hdr_o   (buf_hdr),
    .data_o  (buf_data),
    .v_o     (buf_v),
    .yumi_i  (buf_yumi)
  );

  assign wr_not_rd = buf_hdr.msg inside {csr_bridge_pkg::MSG_WR, csr_bridge_pkg::MSG_UC_WR};

  // First cycle of a buffered command, before the response is pending
  assign v_n = buf_v & ~v_r;

  // Exact match on the full address, no partial decode
  always_comb
  begin
    addr_hit = '0;
    addr_hit[`CSR_IDX_SCRATCH] = (buf_hdr.addr == `CSR_ADDR_SCRATCH);
    addr_hit[`CSR_IDX_CTRL]    = (buf_hdr.addr == `CSR_ADDR_CTRL);
    addr_hit[`CSR_IDX_COUNT]   = (buf_hdr.addr == `CSR_ADDR_COUNT);
    addr_hit[`CSR_IDX_COMPARE] = (buf_hdr.addr == `CSR_ADDR_COMPARE);
    addr_hit[`CSR_IDX_STATUS]  = (buf_hdr.addr == `CSR_ADDR_STATUS);
  end

  assign reg_bus.r_v   = {`CSR_NUM_REGS{v_n & ~wr_not_rd}} & addr_hit;
  assign reg_bus.w_v   = {`CSR_NUM_REGS{v_n &  wr_not_rd}} & addr_hit;
  assign reg_bus.addr  = buf_hdr.addr;
  assign reg_bus.size  = buf_hdr.size;
  assign reg_bus.wdata = buf_data;

  // Pending flag and read selector both drop when the response is taken
  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      v_r   <= 1'b0;
      r_v_r <= '0;
    end
    else if (buf_yumi)
    begin
      v_r   <= 1'b0;
      r_v_r <= '0;
    end
    else if (v_n)
    begin
      v_r   <= 1'b1;
      r_v_r <= reg_bus.r_v;
    end
  end

  // Writes and unmapped reads leave the selector empty, giving zero data
  always_comb
  begin
    rdata_sel = '0;
    for (int i = 0; i < `CSR_NUM_REGS; i++)
    begin
      if (r_v_r[i])
        rdata_sel = reg_bus.rdata[i];
    end
  end

  assign rev_hdr_o  = buf_hdr;
  assign rev_data_o = replicate(rdata_sel, buf_hdr.size);
  assign rev_v_o    = v_r;
  assign buf_yumi   = v_r & rev_ready_and_i;

endmodule

// File: csr_file.sv
// ==============================
// Five 64-bit control registers that steer the cycle timer
// Driven by strobes on the register bus, raises irq_o on a timer match
// ==============================
`timescale 1ns/1ps
`include "csr_bridge_defs.svh"

module csr_file
(
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  reg_bus_if.regfile             reg_bus,
  input  logic [`CSR_DATA_W-1:0] timer_count_i,
  input  logic                   timer_match_i,
  output logic                   timer_enable_o,
  output logic                   timer_load_o,
  output logic [`CSR_DATA_W-1:0] timer_load_value_o,
  output logic [`CSR_DATA_W-1:0] timer_compare_o,
  output logic                   irq_o
);

  logic [`CSR_DATA_W-1:0] scratch_r;
  logic [`CSR_DATA_W-1:0] ctrl_r;
  logic [`CSR_DATA_W-1:0] compare_r;
  logic                   match_flag_r;
  logic [`CSR_NUM_REGS-1:0][`CSR_DATA_W-1:0] rd_val;

  // Replaces only the low 2^size bytes of the old value
  function automatic logic [`CSR_DATA_W-1:0] merge
  (
    input logic [`CSR_DATA_W-1:0] old_val,
    input logic [`CSR_DATA_W-1:0] new_val,
    input csr_bridge_pkg::size_e  size
  );
    logic [`CSR_DATA_W-1:0] mask;
    case (size)
      csr_bridge_pkg::SIZE_1: mask = 64'h0000_0000_0000_00ff;
      csr_bridge_pkg::SIZE_2: mask = 64'h0000_0000_0000_ffff;
      csr_bridge_pkg::SIZE_4: mask = 64'h0000_0000_ffff_ffff;
      default:                mask = '1;
    endcase
    merge = (old_val & ~mask) | (new_val & mask);
  endfunction

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      scratch_r    <= '0;
      ctrl_r       <= '0;
      compare_r    <= '0;
      match_flag_r <= 1'b0;
    end
    else
    begin
      if (reg_bus.w_v[`CSR_IDX_SCRATCH])
        scratch_r <= merge(scratch_r, reg_bus.wdata, reg_bus.size);
      if (reg_bus.w_v[`CSR_IDX_CTRL])
        ctrl_r <= merge(ctrl_r, reg_bus.wdata, reg_bus.size);
      if (reg_bus.w_v[`CSR_IDX_COMPARE])
        compare_r <= merge(compare_r, reg_bus.wdata, reg_bus.size);
      // A new match wins over a clear in the same cycle so no event is lost
      if (timer_match_i)
        match_flag_r <= 1'b1;
      else if (reg_bus.w_v[`CSR_IDX_STATUS] && reg_bus.wdata[0])
        match_flag_r <= 1'b0;
    end
  end

  // COUNT lives in the timer, a write here just loads it
  assign timer_load_o       = reg_bus.w_v[`CSR_IDX_COUNT];
  assign timer_load_value_o = merge(timer_count_i, reg_bus.wdata, reg_bus.size);
  assign timer_enable_o     = ctrl_r[0];
  assign timer_compare_o    = compare_r;
  assign irq_o              = match_flag_r & ctrl_r[1];

  always_comb
  begin
    rd_val                   = '0;
    rd_val[`CSR_IDX_SCRATCH] = scratch_r;
    rd_val[`CSR_IDX_CTRL]    = ctrl_r;
    rd_val[`CSR_IDX_COUNT]   = timer_count_i;
    rd_val[`CSR_IDX_COMPARE] = compare_r;
    rd_val[`CSR_IDX_STATUS]  = {{(`CSR_DATA_W-1){1'b0}}, match_flag_r};
  end

  // Read data is captured on the strobe edge and held until the next read
  always_ff @(posedge clk_i)
  begin
    for (int i = 0; i < `CSR_NUM_REGS; i++)
    begin
      if (reg_bus.r_v[i])
        reg_bus.rdata[i] <= rd_val[i];
    end
  end

endmodule

// File: cycle_timer.sv
// ==============================
// Loadable free-running 64-bit cycle counter with a compare match
// Steered by the control registers, reports back a one-cycle match pulse
// ==============================
`timescale 1ns/1ps
`include "csr_bridge_defs.svh"

module cycle_timer
(
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  logic                   enable_i,
  input  logic                   load_i,
  input  logic [`CSR_DATA_W-1:0] load_value_i,
  input  logic [`CSR_DATA_W-1:0] compare_i,
  output logic [`CSR_DATA_W-1:0] count_o,
  output logic                   match_o
);

  logic [`CSR_DATA_W-1:0] count_r;
  logic [`CSR_DATA_W-1:0] count_inc;
  logic                   match_r;

  assign count_inc = count_r + {{(`CSR_DATA_W-1){1'b0}}, 1'b1};

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      count_r <= '0;
      match_r <= 1'b0;
    end
    else
    begin
      // A load takes priority over counting and never signals a match
      if (load_i)
        count_r <= load_value_i;
      else if (enable_i)
        count_r <= count_inc;
      // The counter moves every enabled cycle so this can only last one cycle
      match_r <= enable_i & ~load_i & (count_inc == compare_i);
    end
  end

  assign count_o = count_r;
  assign match_o = match_r;

endmodule

// File: csr_bridge_top.sv
// ==============================
// Top level of the CSR bridge subsystem
// Plain stream ports in and out, timer interrupt on irq_o
// ==============================
`timescale 1ns/1ps
`include "csr_bridge_defs.svh"

module csr_bridge_top
(
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  // Command stream, one beat per message
  input  logic [1:0]             fwd_msg_i,
  input  logic [`CSR_ADDR_W-1:0] fwd_addr_i,
  input  logic [`CSR_SIZE_W-1:0] fwd_size_i,
  input  logic [`CSR_DATA_W-1:0] fwd_data_i,
  input  logic                   fwd_v_i,
  output logic                   fwd_ready_and_o,
  // Response stream, header echoes the command
  output logic [1:0]             rev_msg_o,
  output logic [`CSR_ADDR_W-1:0] rev_addr_o,
  output logic [`CSR_SIZE_W-1:0] rev_size_o,
  output logic [`CSR_DATA_W-1:0] rev_data_o,
  output logic                   rev_v_o,
  input  logic                   rev_ready_and_i,
  output logic                   irq_o
);

  csr_bridge_pkg::mem_header_s fwd_hdr;
  csr_bridge_pkg::mem_header_s rev_hdr;
  logic                        timer_enable;
  logic                        timer_load;
  logic [`CSR_DATA_W-1:0]      timer_load_value;
  logic [`CSR_DATA_W-1:0]      timer_compare;
  logic [`CSR_DATA_W-1:0]      timer_count;
  logic                        timer_match;

  reg_bus_if reg_bus ();

  assign fwd_hdr.msg  = csr_bridge_pkg::msg_e'(fwd_msg_i);
  assign fwd_hdr.addr = fwd_addr_i;
  assign fwd_hdr.size = csr_bridge_pkg::size_e'(fwd_size_i);

  assign rev_msg_o  = rev_hdr.msg;
  assign rev_addr_o = rev_hdr.addr;
  assign rev_size_o = rev_hdr.size;

  reg_bridge reg_bridge_i
  (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .fwd_hdr_i       (fwd_hdr),
    .fwd_data_i      (fwd_data_i),
    .fwd_v_i         (fwd_v_i),
    .fwd_ready_and_o (fwd_ready_and_o),
    .rev_hdr_o       (rev_hdr),
    .rev_data_o      (rev_data_o),
    .rev_v_o         (rev_v_o),
    .rev_ready_and_i (rev_ready_and_i),
    .reg_bus         (reg_bus.bridge)
  );

  csr_file csr_file_i
  (
    .clk_i              (clk_i),
    .rst_n_i            (rst_n_i),
    .reg_bus            (reg_bus.regfile),
    .timer_count_i      (timer_count),
    .timer_match_i      (timer_match),
    .timer_enable_o     (timer_enable),
    .timer_load_o       (timer_load),
    .timer_load_value_o (timer_load_value),
    .timer_compare_o    (timer_compare),
    .irq_o              (irq_o)
  );

  cycle_timer cycle_timer_i
  (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .enable_i     (timer_enable),
    .load_i       (timer_load),
    .load_value_i (timer_load_value),
    .compare_i    (timer_compare),
    .count_o      (timer_count),
    .match_o      (timer_match)
  );

endmodule

// File: tb_csr_bridge.sv
// ==============================
// Testbench for the CSR bridge top level
// Drives commands on the falling edge and checks every response as it is taken
// ==============================
`timescale 1ns/1ps
`include "csr_bridge_defs.svh"

module tb_csr_bridge;

  localparam int MAX_POLLS = 64;

  logic                   clk;
  logic                   rst_n;
  logic [1:0]             fwd_msg;
  logic [`CSR_ADDR_W-1:0] fwd_addr;
  logic [`CSR_SIZE_W-1:0] fwd_size;
  logic [`CSR_DATA_W-1:0] fwd_data;
  logic                   fwd_v;
  logic                   fwd_ready_and;
  logic [1:0]             rev_msg;
  logic [`CSR_ADDR_W-1:0] rev_addr;
  logic [`CSR_SIZE_W-1:0] rev_size;
  logic [`CSR_DATA_W-1:0] rev_data;
  logic                   rev_v;
  logic                   rev_ready_and;
  logic                   irq;

  // Expected responses in issue order, one entry per accepted command
  csr_bridge_pkg::mem_header_s exp_hdr_q[$];
  logic [`CSR_DATA_W-1:0]      exp_data_q[$];
  bit                          exp_chk_q[$];

  csr_bridge_pkg::mem_header_s mon_exp_hdr;
  csr_bridge_pkg::mem_header_s mon_act_hdr;
  logic [`CSR_DATA_W-1:0]      mon_exp_data;
  bit                          mon_chk;
  logic [`CSR_DATA_W-1:0]      last_rdata;

  // Shadow copies of the registers that only the stream changes
  logic [`CSR_DATA_W-1:0] scratch_shadow;
  logic [`CSR_DATA_W-1:0] ctrl_shadow;
  logic [`CSR_DATA_W-1:0] compare_shadow;
  logic [`CSR_DATA_W-1:0] count_shadow;

  logic [31:0] stim_seed = 32'd43;
  logic [31:0] stall_seed = 32'd43;
  bit          stall_en = 1'b0;
  int          issued_count = 0;
  int          resp_count = 0;
  int          cycle_count = 0;

  csr_bridge_top csr_bridge_top_i
  (
    .clk_i           (clk),
    .rst_n_i         (rst_n),
    .fwd_msg_i       (fwd_msg),
    .fwd_addr_i      (fwd_addr),
    .fwd_size_i      (fwd_size),
    .fwd_data_i      (fwd_data),
    .fwd_v_i         (fwd_v),
    .fwd_ready_and_o (fwd_ready_and),
    .rev_msg_o       (rev_msg),
    .rev_addr_o      (rev_addr),
    .rev_size_o      (rev_size),
    .rev_data_o      (rev_data),
    .rev_v_o         (rev_v),
    .rev_ready_and_i (rev_ready_and),
    .irq_o           (irq)
  );

  initial
  begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // Plain LCG step with the usual 32-bit constants
  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    lcg_next = state * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic next_rand(output logic [31:0] value);
    stim_seed = lcg_next(stim_seed);
    value = stim_seed;
  endtask

  task automatic rand_word(output logic [`CSR_DATA_W-1:0] value);
    logic [31:0] hi;
    logic [31:0] lo;
    next_rand(hi);
    next_rand(lo);
    value = {hi, lo};
  endtask

  function automatic bit is_write(input csr_bridge_pkg::msg_e msg);
    is_write = (msg == csr_bridge_pkg::MSG_WR) || (msg == csr_bridge_pkg::MSG_UC_WR);
  endfunction

  // Only the low 2^size bytes take the new data, byte by byte
  function automatic logic [`CSR_DATA_W-1:0] apply_write
  (
    input logic [`CSR_DATA_W-1:0] old_val,
    input logic [`CSR_DATA_W-1:0] new_val,
    input csr_bridge_pkg::size_e  size
  );
    int nbytes;
    nbytes = 1 << size;
    apply_write = old_val;
    for (int i = 0; i < nbytes; i++)
      apply_write[i*8 +: 8] = new_val[i*8 +: 8];
  endfunction

  // Byte i of the response repeats byte (i mod 2^size) of the source value
  function automatic logic [`CSR_DATA_W-1:0] expected_rev_data
  (
    input logic [`CSR_DATA_W-1:0] reg_val,
    input csr_bridge_pkg::msg_e   msg,
    input csr_bridge_pkg::size_e  size,
    input bit                     mapped
  );
    logic [`CSR_DATA_W-1:0] src;
    int nbytes;
    src = (is_write(msg) || !mapped) ? '0 : reg_val;
    nbytes = 1 << size;
    for (int i = 0; i < `CSR_DATA_W / 8; i++)
      expected_rev_data[i*8 +: 8] = src[(i % nbytes)*8 +: 8];
  endfunction

  task automatic stop_run();
    $display("Simulation FAILED");
    $fatal(1);
  endtask

  task automatic report_failure(input string what);
    $display("%s", what);
    stop_run();
  endtask

  task automatic check_header
  (
    input csr_bridge_pkg::mem_header_s exp_hdr,
    input csr_bridge_pkg::mem_header_s act_hdr
  );
    if (act_hdr !== exp_hdr)
    begin
      $display("FAILED rev_msg_o/rev_addr_o/rev_size_o expected 0x%h actual 0x%h",
               exp_hdr, act_hdr);
      stop_run();
    end
  endtask

  task automatic check_data
  (
    input logic [`CSR_DATA_W-1:0] exp_data,
    input logic [`CSR_DATA_W-1:0] act_data
  );
    if (act_data !== exp_data)
    begin
      $display("FAILED rev_data_o expected 0x%h actual 0x%h", exp_data, act_data);
      stop_run();
    end
  endtask

  task automatic check_irq(input logic exp_irq, input logic act_irq);
    if (act_irq !== exp_irq)
    begin
      $display("FAILED irq_o expected 0x%h actual 0x%h", exp_irq, act_irq);
      stop_run();
    end
  endtask

  // Queues the expected response, then holds the beat until it is accepted
  task automatic issue_cmd
  (
    input csr_bridge_pkg::msg_e   msg,
    input logic [`CSR_ADDR_W-1:0] addr,
    input csr_bridge_pkg::size_e  size,
    input logic [`CSR_DATA_W-1:0] data,
    input logic [`CSR_DATA_W-1:0] exp_data,
    input bit                     chk_data
  );
    csr_bridge_pkg::mem_header_s hdr;
    bit accepted;
    hdr.msg  = msg;
    hdr.addr = addr;
    hdr.size = size;
    exp_hdr_q.push_back(hdr);
    exp_data_q.push_back(exp_data);
    exp_chk_q.push_back(chk_data);
    @(negedge clk);
    fwd_msg  = msg;
    fwd_addr = addr;
    fwd_size = size;
    fwd_data = data;
    fwd_v    = 1'b1;
    accepted = 1'b0;
    while (!accepted)
    begin
      @(posedge clk);
      accepted = fwd_ready_and;
    end
    issued_count++;
    @(negedge clk);
    fwd_v = 1'b0;
  endtask

  task automatic write_reg
  (
    input logic [`CSR_ADDR_W-1:0] addr,
    input csr_bridge_pkg::size_e  size,
    input logic [`CSR_DATA_W-1:0] data,
    input bit                     mapped
  );
    logic [31:0] r;
    csr_bridge_pkg::msg_e msg;
    next_rand(r);
    msg = r[31] ? csr_bridge_pkg::MSG_UC_WR : csr_bridge_pkg::MSG_WR;
    issue_cmd(msg, addr, size, data, expected_rev_data('0, msg, size, mapped), 1'b1);
  endtask

  // Read beats carry junk data, the bridge must ignore it
  task automatic read_reg
  (
    input logic [`CSR_ADDR_W-1:0] addr,
    input csr_bridge_pkg::size_e  size,
    input logic [`CSR_DATA_W-1:0] model,
    input bit                     mapped,
    input bit                     chk_data
  );
    logic [31:0] r;
    csr_bridge_pkg::msg_e msg;
    next_rand(r);
    msg = r[31] ? csr_bridge_pkg::MSG_UC_RD : csr_bridge_pkg::MSG_RD;
    issue_cmd(msg, addr, size, {r, ~r}, expected_rev_data(model, msg, size, mapped),
              chk_data);
  endtask

  // Sampled on the falling edge, the monitor counts on the rising one
  task automatic wait_responses();
    while (resp_count < issued_count)
      @(negedge clk);
  endtask

  // Each response beat is compared on the edge that takes it
  always @(posedge clk)
  begin
    if (rst_n && rev_v)
    begin
      if (fwd_ready_and)
        report_failure("fwd_ready_and_o is high while a response is pending");
      else if (rev_ready_and)
      begin
        if (exp_hdr_q.size() == 0)
          report_failure("response seen with no command outstanding");
        else
        begin
          mon_exp_hdr  = exp_hdr_q.pop_front();
          mon_exp_data = exp_data_q.pop_front();
          mon_chk      = exp_chk_q.pop_front();
          mon_act_hdr.msg  = csr_bridge_pkg::msg_e'(rev_msg);
          mon_act_hdr.addr = rev_addr;
          mon_act_hdr.size = csr_bridge_pkg::size_e'(rev_size);
          check_header(mon_exp_hdr, mon_act_hdr);
          if (mon_chk)
            check_data(mon_exp_data, rev_data);
          last_rdata = rev_data;
          resp_count++;
        end
      end
    end
  end

  // While stalling, ready is high about three cycles in four
  always @(negedge clk)
  begin
    if (stall_en)
    begin
      stall_seed = lcg_next(stall_seed);
      rev_ready_and = (stall_seed[31:30] != 2'b00);
    end
    else
      rev_ready_and = 1'b1;
  end

  // Limit grows with every accepted command
  always @(posedge clk)
  begin
    cycle_count++;
    if (cycle_count > 20 * issued_count + 2000)
      report_failure("Timeout, the DUT stopped accepting or answering commands");
  end

  initial
  begin
    logic [31:0]              r;
    logic [`CSR_DATA_W-1:0]   w;
    csr_bridge_pkg::size_e    sz;
    logic [`CSR_ADDR_W-1:0]   unmapped [3];
    int                       polls;
    bit                       done;
    unmapped[0] = 20'h00028;
    unmapped[1] = 20'h00004;
    unmapped[2] = 20'hfff00;
    fwd_msg  = '0;
    fwd_addr = '0;
    fwd_size = '0;
    fwd_data = '0;
    fwd_v    = 1'b0;
    rev_ready_and = 1'b1;
    rst_n = 1'b0;
    scratch_shadow = '0;
    ctrl_shadow    = '0;
    compare_shadow = '0;
    count_shadow   = '0;
    repeat (8) @(negedge clk);
    rst_n = 1'b1;
    if (!fwd_ready_and || rev_v)
      report_failure("Handshake outputs are wrong after reset");
    check_irq(1'b0, irq);

    // Random SCRATCH writes, each followed by a read of random size
    for (int i = 0; i < 20; i++)
    begin
      next_rand(r);
      rand_word(w);
      sz = csr_bridge_pkg::size_e'(r[29:28]);
      write_reg(`CSR_ADDR_SCRATCH, sz, w, 1'b1);
      scratch_shadow = apply_write(scratch_shadow, w, sz);
      next_rand(r);
      read_reg(`CSR_ADDR_SCRATCH, csr_bridge_pkg::size_e'(r[29:28]), scratch_shadow,
               1'b1, 1'b1);
    end
    wait_responses();

    // Unmapped commands answer with zero data and leave SCRATCH alone
    for (int i = 0; i < 3; i++)
    begin
      rand_word(w);
      next_rand(r);
      write_reg(unmapped[i], csr_bridge_pkg::SIZE_8, w, 1'b0);
      read_reg(unmapped[i], csr_bridge_pkg::size_e'(r[29:28]), '0, 1'b0, 1'b1);
    end
    read_reg(`CSR_ADDR_SCRATCH, csr_bridge_pkg::SIZE_8, scratch_shadow, 1'b1, 1'b1);
    wait_responses();

    // Same traffic mix with random stalls on the response side
    @(posedge clk);
    stall_en = 1'b1;
    for (int i = 0; i < 30; i++)
    begin
      next_rand(r);
      rand_word(w);
      sz = csr_bridge_pkg::size_e'(r[29:28]);
      if (r[31])
      begin
        write_reg(`CSR_ADDR_SCRATCH, sz, w, 1'b1);
        scratch_shadow = apply_write(scratch_shadow, w, sz);
      end
      else
        read_reg(`CSR_ADDR_SCRATCH, sz, scratch_shadow, 1'b1, 1'b1);
    end
    wait_responses();
    @(posedge clk);
    stall_en = 1'b0;

    // COUNT holds a loaded value while CTRL still has the timer off
    next_rand(r);
    rand_word(w);
    sz = csr_bridge_pkg::size_e'(r[29:28]);
    write_reg(`CSR_ADDR_COUNT, sz, w, 1'b1);
    count_shadow = apply_write(count_shadow, w, sz);
    read_reg(`CSR_ADDR_COUNT, csr_bridge_pkg::SIZE_8, count_shadow, 1'b1, 1'b1);
    read_reg(`CSR_ADDR_COUNT, csr_bridge_pkg::SIZE_8, count_shadow, 1'b1, 1'b1);
    wait_responses();

    // Timer runs from 0 up to a compare value of 50 with the interrupt enabled
    write_reg(`CSR_ADDR_COUNT, csr_bridge_pkg::SIZE_8, 64'd0, 1'b1);
    write_reg(`CSR_ADDR_COMPARE, csr_bridge_pkg::SIZE_8, 64'd50, 1'b1);
    compare_shadow = apply_write(compare_shadow, 64'd50, csr_bridge_pkg::SIZE_8);
    write_reg(`CSR_ADDR_CTRL, csr_bridge_pkg::SIZE_8, 64'd3, 1'b1);
    ctrl_shadow = apply_write(ctrl_shadow, 64'd3, csr_bridge_pkg::SIZE_8);
    next_rand(r);
    read_reg(`CSR_ADDR_CTRL, csr_bridge_pkg::size_e'(r[29:28]), ctrl_shadow, 1'b1, 1'b1);
    read_reg(`CSR_ADDR_COMPARE, csr_bridge_pkg::size_e'(r[27:26]), compare_shadow,
             1'b1, 1'b1);
    polls = 0;
    done  = 1'b0;
    while (!done)
    begin
      read_reg(`CSR_ADDR_STATUS, csr_bridge_pkg::SIZE_8, '0, 1'b1, 1'b0);
      wait_responses();
      // Only bit 0 of STATUS may ever be set
      check_data({63'h0, last_rdata[0]}, last_rdata);
      done = last_rdata[0];
      polls++;
      if (!done && polls >= MAX_POLLS)
        report_failure("STATUS match flag never set by the timer");
    end
    check_irq(1'b1, irq);
    write_reg(`CSR_ADDR_STATUS, csr_bridge_pkg::SIZE_8, 64'd1, 1'b1);
    wait_responses();
    check_irq(1'b0, irq);
    read_reg(`CSR_ADDR_STATUS, csr_bridge_pkg::SIZE_8, '0, 1'b1, 1'b1);
    wait_responses();

    if (resp_count != issued_count || exp_hdr_q.size() != 0)
      report_failure("Response count does not match the accepted commands");
    else
    begin
      $display("Simulation PASSED");
      $finish;
    end
  end

endmodule

// File: csr_bridge.f
+incdir+.
csr_bridge_pkg.sv
reg_bus_if.sv
fwd_buffer.sv
reg_bridge.sv
csr_file.sv
cycle_timer.sv
csr_bridge_top.sv
tb_csr_bridge.sv

// File: Makefile
# Verilator build and run of the CSR bridge testbench
# Pass or fail is the exit status of the simulation binary

VERILATOR ?= verilator
TOP       ?= tb_csr_bridge
FILELIST  ?= csr_bridge.f
BUILD_DIR ?= obj_dir
VFLAGS    ?=

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) --binary --timing --top-module $(TOP) -Mdir $(BUILD_DIR) \
		-f $(FILELIST) $(VFLAGS)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
